// ==== branch_slice.f ====
branch_pkg.sv
rf_read_if.sv
branch_decoder.sv
reg_file.sv
stage_reg.sv
branch_unit.sv
branch_slice.sv
branch_slice_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run with Verilator, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module branch_slice_tb \
    -f branch_slice.f -o sim_branch_slice > build.log 2>&1 \
    && ./obj_dir/sim_branch_slice > sim.log 2>&1 \
    || { echo "build or simulation run failed, see build.log and sim.log"; exit 1; }

grep -q "Simulation finished: FAIL" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== branch_slice_tb.sv ====
`timescale 1ns/1ns

module branch_slice_tb;

    import branch_pkg::*;

    localparam int N_RANDOM   = 240;
    localparam int N_DIRECTED = 15;
    localparam int NUM_INSTR  = N_RANDOM + N_DIRECTED;

    typedef struct packed {
        ex_result_t res;
        int         cap;
    } exp_entry_t;

    logic        clk;
    logic        rst_i;
    logic        valid_i;
    logic [31:0] pc_i;
    logic [31:0] inst_i;
    logic [5:0]  exc_i;
    logic        wb_we_i;
    logic [4:0]  wb_addr_i;
    logic [31:0] wb_data_i;
    logic        valid_o;
    logic        redirect_o;
    logic [31:0] target_o;
    logic        link_we_o;
    logic [4:0]  link_addr_o;
    logic [31:0] link_data_o;
    logic [5:0]  exc_o;

    logic [31:0] shadow [32];
    logic [31:0] lfsr_state = 32'd64;
    exp_entry_t  exp_q [$];
    int          cyc = 0;
    int          val_errs = 0;
    int          seq_errs = 0;

    branch_slice dut (
        .clk         (clk),
        .rst_i       (rst_i),
        .valid_i     (valid_i),
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .exc_i       (exc_i),
        .wb_we_i     (wb_we_i),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i),
        .valid_o     (valid_o),
        .redirect_o  (redirect_o),
        .target_o    (target_o),
        .link_we_o   (link_we_o),
        .link_addr_o (link_addr_o),
        .link_data_o (link_data_o),
        .exc_o       (exc_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // rising edges seen so far
    always @(posedge clk) cyc <= cyc + 1;

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic ex_result_t ref_branch(input logic [31:0] pc, input logic [31:0] inst,
                                              input logic [5:0] exc, input logic [31:0] regs [32]);
        logic [31:0] rj_v;
        logic [31:0] rd_v;
        logic [31:0] off16;
        logic [31:0] off26;
        logic        taken;
        logic        known;
        logic        link;
        logic [5:0]  e;
        ex_result_t  r;
        rj_v  = regs[inst[9:5]];
        rd_v  = regs[inst[4:0]];
        off16 = {{16{inst[25]}}, inst[25:10]} << 2;
        off26 = {{6{inst[9]}}, inst[9:0], inst[25:10]} << 2;
        taken = 1'b1;
        known = 1'b1;
        link  = 1'b0;
        r = '0;
        r.target    = pc + off16;
        r.link_data = pc + 32'd4;
        case (inst[31:26])
            OP_BEQ:  taken = rj_v == rd_v;
            OP_BNE:  taken = rj_v != rd_v;
            OP_BLT:  taken = $signed(rj_v) < $signed(rd_v);
            OP_BGE:  taken = $signed(rj_v) >= $signed(rd_v);
            OP_BLTU: taken = rj_v < rd_v;
            OP_BGEU: taken = rj_v >= rd_v;
            OP_B:    r.target = pc + off26;
            OP_BL: begin
                r.target    = pc + off26;
                link        = 1'b1;
                r.link_addr = 5'd1;
            end
            OP_JIRL: begin
                r.target    = rj_v + off16;
                link        = 1'b1;
                r.link_addr = inst[4:0];
            end
            default: known = 1'b0;
        endcase
        e = exc;
        e[EXC_INE_SLOT] = e[EXC_INE_SLOT] | ~known;
        r.redirect = known && taken && (e == 6'd0);
        r.link_we  = link && (e == 6'd0);
        r.exc      = e;
        return r;
    endfunction

    task automatic report_value(input string name, input logic [31:0] exp,
                                input logic [31:0] got);
        $display("Fail %s exp 0x%0h got 0x%0h at %0t", name, exp, got, $time);
        val_errs++;
    endtask

    // target only matters when taken, link fields only when written
    task automatic check_result(input ex_result_t exp, input ex_result_t got);
        if (got.redirect !== exp.redirect) begin
            report_value("redirect_o", 32'(exp.redirect), 32'(got.redirect));
        end
        if (exp.redirect && got.target !== exp.target) begin
            report_value("target_o", exp.target, got.target);
        end
        if (got.link_we !== exp.link_we) begin
            report_value("link_we_o", 32'(exp.link_we), 32'(got.link_we));
        end
        if (exp.link_we && got.link_addr !== exp.link_addr) begin
            report_value("link_addr_o", 32'(exp.link_addr), 32'(got.link_addr));
        end
        if (exp.link_we && got.link_data !== exp.link_data) begin
            report_value("link_data_o", exp.link_data, got.link_data);
        end
    endtask

    task automatic check_exc(input logic [5:0] exp, input logic [5:0] got);
        if (got !== exp) report_value("exc_o", 32'(exp), 32'(got));
    endtask

    always @(negedge clk) begin : compare_outputs
        exp_entry_t e;
        ex_result_t got;
        if (!rst_i && valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("valid_o came with no instruction outstanding at %0t", $time);
                seq_errs++;
            end else begin
                e = exp_q.pop_front();
                if (cyc != e.cap + 1) begin
                    $display("result of edge %0d arrived at edge %0d", e.cap, cyc);
                    seq_errs++;
                end
                got.redirect  = redirect_o;
                got.target    = target_o;
                got.link_we   = link_we_o;
                got.link_addr = link_addr_o;
                got.link_data = link_data_o;
                got.exc       = exc_o;
                check_result(e.res, got);
                check_exc(e.res.exc, exc_o);
            end
        end else if (!rst_i && valid_o !== 1'b0) begin
            $display("valid_o is unknown at %0t", $time);
            seq_errs++;
        end
    end

    task automatic idle(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic wb_write(input logic [4:0] addr, input logic [31:0] data);
        wb_we_i   = 1'b1;
        wb_addr_i = addr;
        wb_data_i = data;
        shadow[addr] = data;
        @(negedge clk);
        wb_we_i = 1'b0;
    endtask

    task automatic issue(input logic [31:0] pc, input logic [31:0] inst, input logic [5:0] exc);
        exp_entry_t e;
        e.res = ref_branch(pc, inst, exc, shadow);
        e.cap = cyc + 1;
        exp_q.push_back(e);
        if (e.res.link_we && e.res.link_addr != 5'd0) shadow[e.res.link_addr] = e.res.link_data;
        valid_i = 1'b1;
        pc_i    = pc;
        inst_i  = inst;
        exc_i   = exc;
        @(negedge clk);
        valid_i = 1'b0;
        // no forwarding, a younger reader waits one extra cycle
        if (e.res.link_we) @(negedge clk);
    endtask

    function automatic logic [5:0] opcode_of(input logic [3:0] sel);
        case (sel)
            4'd0:    return OP_BEQ;
            4'd1:    return OP_BNE;
            4'd2:    return OP_BLT;
            4'd3:    return OP_BGE;
            4'd4:    return OP_BLTU;
            4'd5:    return OP_BGEU;
            4'd6:    return OP_B;
            4'd7:    return OP_BL;
            default: return OP_JIRL;
        endcase
    endfunction

    initial begin : stimulus
        logic [3:0]  sel;
        logic [5:0]  opc;
        logic [4:0]  rj;
        logic [4:0]  rd;
        logic [31:0] val;
        int          gap;
        rst_i     = 1'b1;
        valid_i   = 1'b0;
        pc_i      = '0;
        inst_i    = '0;
        exc_i     = '0;
        wb_we_i   = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        shadow[0] = '0;
        repeat (8) @(negedge clk);
        rst_i = 1'b0;
        if (valid_o !== 1'b0 || redirect_o !== 1'b0 || link_we_o !== 1'b0) begin
            $display("outputs not cleared after reset");
            seq_errs++;
        end
        // a few registers hold sign and carry corner values
        for (int i = 1; i < 32; i++) begin
            case (i)
                3:       val = 32'h8000_0000;
                4:       val = 32'hffff_ffff;
                5:       val = 32'h7fff_ffff;
                6:       val = 32'h0000_0001;
                default: val = rand_bits(32);
            endcase
            wb_write(5'(i), val);
        end
        // bl result compared by the next beq
        issue(shadow[2] - 32'd4, {OP_BL, 16'h0010, 10'h000}, 6'd0);
        issue(32'h0000_1000, {OP_BEQ, 16'h0004, 5'd1, 5'd2}, 6'd0);
        issue(32'h0000_2000, {OP_JIRL, 16'hfff0, 5'd7, 5'd0}, 6'd0);
        // r0 below r6 only while r0 still reads zero
        issue(32'h0000_3000, {OP_BLTU, 16'h0008, 5'd0, 5'd6}, 6'd0);
        issue(32'h0000_3004, {OP_BEQ, 16'h8000, 5'd0, 5'd0}, 6'd0);
        issue(32'h4000_0000, {OP_B, 16'h0000, 10'h200}, 6'd0);
        issue(32'h0000_0100, {OP_BL, 16'hffff, 10'h1ff}, 6'd0);
        issue(32'h0000_5000, {6'h00, 26'h3ff_ffff}, 6'd0);
        issue(32'h0000_5004, {6'h3f, 26'h000_0421}, 6'd0);
        issue(32'h0000_5008, {6'h12, 26'h000_0043}, 6'd0);
        issue(32'h0000_500c, {6'h1c, 26'h000_0085}, 6'd0);
        issue(32'h0000_6000, {OP_BL, 16'h0020, 10'h000}, 6'b000001);
        issue(32'h0000_6004, {OP_JIRL, 16'h0004, 5'd9, 5'd10}, 6'b100000);
        issue(32'h0000_6008, {OP_B, 16'h0040, 10'h000}, 6'b001000);
        issue(32'h0000_600c, {OP_BEQ, 16'h0004, 5'd3, 5'd3}, 6'b000100);
        for (int i = 0; i < N_RANDOM; i++) begin
            sel = 4'(rand_bits(4));
            opc = (sel < 4'd9) ? opcode_of(sel) : 6'(rand_bits(6));
            rj  = rand_bits(1) != 0 ? 5'(rand_bits(3)) : 5'(rand_bits(5));
            rd  = rand_bits(2) == 0 ? rj : 5'(rand_bits(5));
            issue(rand_bits(30) << 2, {opc, 16'(rand_bits(16)), rj, rd},
                  rand_bits(3) == 0 ? 6'(rand_bits(6)) : 6'd0);
            gap = int'(rand_bits(2));
            idle(gap == 3 ? 0 : gap);
        end
        idle(4);
        if (exp_q.size() != 0) begin
            $display("%0d results never appeared on valid_o", exp_q.size());
            seq_errs++;
        end
        $display("errors: value %0d, sequence %0d", val_errs, seq_errs);
        if (val_errs == 0 && seq_errs == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_INSTR * 4 + 100) @(posedge clk);
        $display("run did not complete within %0d cycles", NUM_INSTR * 4 + 100);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== branch_slice.sv ====
`timescale 1ns/1ns

module branch_slice (
    input  logic        clk,
    input  logic        rst_i,
    input  logic        valid_i,
    input  logic [31:0] pc_i,
    input  logic [31:0] inst_i,
    input  logic [5:0]  exc_i,
    input  logic        wb_we_i,
    input  logic [4:0]  wb_addr_i,
    input  logic [31:0] wb_data_i,
    output logic        valid_o,
    output logic        redirect_o,
    output logic [31:0] target_o,
    output logic        link_we_o,
    output logic [4:0]  link_addr_o,
    output logic [31:0] link_data_o,
    output logic [5:0]  exc_o
);

    import branch_pkg::*;

    br_op_t       dec_op;
    logic [31:0]  dec_imm;
    logic         dec_link_we;
    logic [4:0]   dec_link_addr;
    logic [5:0]   dec_exc;
    id_dispatch_t id_d;
    id_dispatch_t id_q;
    logic         id_valid;
    ex_result_t   ex_d;
    ex_result_t   ex_q;

    rf_read_if rf_rd ();

    branch_decoder u_decoder (
        .pc_i        (pc_i),
        .inst_i      (inst_i),
        .exc_i       (exc_i),
        .rd_req      (rf_rd.requester),
        .op_o        (dec_op),
        .imm_o       (dec_imm),
        .link_we_o   (dec_link_we),
        .link_addr_o (dec_link_addr),
        .exc_o       (dec_exc)
    );

    // link write lands at the same edge as the output register
    reg_file u_reg_file (
        .clk         (clk),
        .rst_i       (rst_i),
        .rd_rsp      (rf_rd.responder),
        .link_we_i   (ex_d.link_we),
        .link_addr_i (ex_d.link_addr),
        .link_data_i (ex_d.link_data),
        .wb_we_i     (wb_we_i),
        .wb_addr_i   (wb_addr_i),
        .wb_data_i   (wb_data_i)
    );

    // decode result merged with the operand reads
    assign id_d = '{
        pc:        pc_i,
        op:        dec_op,
        imm:       dec_imm,
        rj_val:    rf_rd.rdata[0],
        rd_val:    rf_rd.rdata[1],
        link_we:   dec_link_we,
        link_addr: dec_link_addr,
        exc:       dec_exc
    };

    stage_reg #(.payload_t(id_dispatch_t)) u_id_stage (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (valid_i),
        .data_i  (id_d),
        .valid_o (id_valid),
        .data_o  (id_q)
    );

    branch_unit u_branch_unit (
        .valid_i (id_valid),
        .id_i    (id_q),
        .res_o   (ex_d)
    );

    stage_reg #(.payload_t(ex_result_t)) u_ex_stage (
        .clk     (clk),
        .rst_i   (rst_i),
        .valid_i (id_valid),
        .data_i  (ex_d),
        .valid_o (valid_o),
        .data_o  (ex_q)
    );

    assign redirect_o  = ex_q.redirect && valid_o;
    assign target_o    = ex_q.target;
    assign link_we_o   = ex_q.link_we && valid_o;
    assign link_addr_o = ex_q.link_addr;
    assign link_data_o = ex_q.link_data;
    assign exc_o       = ex_q.exc;

endmodule

// ==== branch_unit.sv ====
`timescale 1ns/1ns

module branch_unit (
    input  logic                     valid_i,
    input  branch_pkg::id_dispatch_t id_i,
    output branch_pkg::ex_result_t   res_o
);

    import branch_pkg::*;

    logic        taken;
    logic        commit;
    logic [31:0] base;

    // rj is always compared against rd
    always_comb begin
        case (id_i.op)
            BR_BEQ:  taken = (id_i.rj_val == id_i.rd_val);
            BR_BNE:  taken = (id_i.rj_val != id_i.rd_val);
            BR_BLT:  taken = ($signed(id_i.rj_val) < $signed(id_i.rd_val));
            BR_BGE:  taken = ($signed(id_i.rj_val) >= $signed(id_i.rd_val));
            BR_BLTU: taken = (id_i.rj_val < id_i.rd_val);
            BR_BGEU: taken = (id_i.rj_val >= id_i.rd_val);
            BR_B,
            BR_BL,
            BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    // jirl is register relative, the rest are pc relative
    assign base = (id_i.op == BR_JIRL) ? id_i.rj_val : id_i.pc;

    // any exception kills the redirect and the link write
    assign commit = valid_i && !(|id_i.exc);

    always_comb begin
        res_o.redirect  = commit && taken;
        res_o.target    = base + id_i.imm;
        res_o.link_we   = commit && id_i.link_we;
        res_o.link_addr = id_i.link_addr;
        res_o.link_data = id_i.pc + 32'd4;
        res_o.exc       = id_i.exc;
    end

endmodule

// ==== stage_reg.sv ====
`timescale 1ns/1ns

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     valid_o,
    output payload_t data_o
);

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
    end

    // payload follows the input every cycle, valid qualifies it
    always_ff @(posedge clk) begin
        data_o <= data_i;
    end

    assert property (@(posedge clk) disable iff (rst_i) !$isunknown(valid_o))
    else
        $error("stage_reg: valid_o is unknown");

endmodule

// ==== reg_file.sv ====
`timescale 1ns/1ns

module reg_file (
    input  logic         clk,
    input  logic         rst_i,
    rf_read_if.responder rd_rsp,
    input  logic         link_we_i,
    input  logic [4:0]   link_addr_i,
    input  logic [31:0]  link_data_i,
    input  logic         wb_we_i,
    input  logic [4:0]   wb_addr_i,
    input  logic [31:0]  wb_data_i
);

    logic [31:0] regs [32];

    // r0 is never written, so it stays zero from reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else begin
            if (wb_we_i && wb_addr_i != 5'd0) begin
                regs[wb_addr_i] <= wb_data_i;
            end
            if (link_we_i && link_addr_i != 5'd0) begin
                regs[link_addr_i] <= link_data_i;
            end
        end
    end

    // combinational reads, disabled or r0 gives zero
    always_comb begin
        for (int p = 0; p < 2; p++) begin
            if (rd_rsp.re[p] && rd_rsp.raddr[p] != 5'd0) begin
                rd_rsp.rdata[p] = regs[rd_rsp.raddr[p]];
            end else begin
                rd_rsp.rdata[p] = 32'd0;
            end
        end
    end

    // link and writeback ports must not collide on a real register
    assert property (@(posedge clk) disable iff (rst_i)
        !(link_we_i && wb_we_i && link_addr_i == wb_addr_i && link_addr_i != 5'd0))
    else
        $error("reg_file: link and writeback both write r%0d", link_addr_i);

endmodule

// ==== branch_decoder.sv ====
`timescale 1ns/1ns

module branch_decoder (
    input  logic [31:0]       pc_i,
    input  logic [31:0]       inst_i,
    input  logic [5:0]        exc_i,
    rf_read_if.requester      rd_req,
    output branch_pkg::br_op_t op_o,
    output logic [31:0]       imm_o,
    output logic              link_we_o,
    output logic [4:0]        link_addr_o,
    output logic [5:0]        exc_o
);

    import branch_pkg::*;

    logic [5:0]  opcode;
    logic [4:0]  rj;
    logic [4:0]  rd;
    logic [31:0] imm_offs16;
    logic [31:0] imm_offs26;
    logic        inst_valid;

    assign opcode = inst_i[31:26];
    assign rj     = inst_i[9:5];
    assign rd     = inst_i[4:0];

    // offsets are word counts, hence the two zero bits
    assign imm_offs16 = {{14{inst_i[25]}}, inst_i[25:10], 2'b00};
    assign imm_offs26 = {{4{inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

    always_comb begin
        op_o           = BR_NOP;
        imm_o          = imm_offs16;
        link_we_o      = 1'b0;
        link_addr_o    = 5'd0;
        inst_valid     = 1'b1;
        rd_req.re      = 2'b00;
        rd_req.raddr   = '{rd, rj};

        case (opcode)
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                rd_req.re = 2'b11;
                case (opcode)
                    OP_BEQ:  op_o = BR_BEQ;
                    OP_BNE:  op_o = BR_BNE;
                    OP_BLT:  op_o = BR_BLT;
                    OP_BGE:  op_o = BR_BGE;
                    OP_BLTU: op_o = BR_BLTU;
                    default: op_o = BR_BGEU;
                endcase
            end
            OP_B: begin
                op_o  = BR_B;
                imm_o = imm_offs26;
            end
            OP_BL: begin
                op_o        = BR_BL;
                imm_o       = imm_offs26;
                link_we_o   = 1'b1;
                link_addr_o = BL_LINK_REG;
            end
            OP_JIRL: begin
                // only rj is needed, target is rj + offs16
                op_o        = BR_JIRL;
                rd_req.re   = 2'b01;
                link_we_o   = 1'b1;
                link_addr_o = rd;
            end
            default: begin
                inst_valid = 1'b0;
            end
        endcase
    end

    // fetch exceptions pass through, decode slot raised on an unknown opcode
    always_comb begin
        exc_o               = exc_i;
        exc_o[EXC_INE_SLOT] = exc_i[EXC_INE_SLOT] | ~inst_valid;
    end

endmodule

// ==== rf_read_if.sv ====
`timescale 1ns/1ns

interface rf_read_if;

    // port 0 reads rj, port 1 reads rd
    logic [1:0]       re;
    logic [1:0][4:0]  raddr;
    logic [1:0][31:0] rdata;

    modport requester (
        output re,
        output raddr,
        input  rdata
    );

    // data comes back in the same cycle
    modport responder (
        input  re,
        input  raddr,
        output rdata
    );

endinterface

// ==== branch_pkg.sv ====
package branch_pkg;

    // major opcodes, inst[31:26]
    localparam logic [5:0] OP_JIRL = 6'h13;
    localparam logic [5:0] OP_B    = 6'h14;
    localparam logic [5:0] OP_BL   = 6'h15;
    localparam logic [5:0] OP_BEQ  = 6'h16;
    localparam logic [5:0] OP_BNE  = 6'h17;
    localparam logic [5:0] OP_BLT  = 6'h18;
    localparam logic [5:0] OP_BGE  = 6'h19;
    localparam logic [5:0] OP_BLTU = 6'h1a;
    localparam logic [5:0] OP_BGEU = 6'h1b;

    // decode slot of the exception vector
    localparam int EXC_INE_SLOT = 3;

    // BL always links to ra
    localparam logic [4:0] BL_LINK_REG = 5'd1;

    typedef enum logic [3:0] {
        BR_NOP,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_B,
        BR_BL,
        BR_JIRL
    } br_op_t;

    // decoded instruction plus operand values
    typedef struct packed {
        logic [31:0] pc;
        br_op_t      op;
        logic [31:0] imm;
        logic [31:0] rj_val;
        logic [31:0] rd_val;
        logic        link_we;
        logic [4:0]  link_addr;
        logic [5:0]  exc;
    } id_dispatch_t;

    // resolved branch
    typedef struct packed {
        logic        redirect;
        logic [31:0] target;
        logic        link_we;
        logic [4:0]  link_addr;
        logic [31:0] link_data;
        logic [5:0]  exc;
    } ex_result_t;

endpackage
